// ==== sim.f ====
usb_host_pkg.sv
max3421_spi.sv
max3421_cmd_rom.sv
usb_host_fsm.sv
usb_midi_host.sv
max3421_model.sv
usb_midi_host_chk.sv
tb_usb_midi_host.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= tb_usb_midi_host
RTL_TOP    ?= usb_midi_host
FILELIST   ?= sim.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= --lint-only --timing --assert -Wno-fatal
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal
PASS_MSG   ?= Simulation completed successfully

SRCS := $(shell grep -v '^+' $(FILELIST))
EXE  := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

$(EXE): $(SRCS) $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: $(EXE)
	./$(EXE) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb_usb_midi_host.sv ====
module tb_usb_midi_host import usb_host_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_DIV   = 2;
  localparam int SETTLE    = 200;
  localparam int POLL      = 50;
  localparam int XFER_WAIT = 5;
  localparam int MAX_BYTES = 9;
  localparam int NUM_XFERS = 10;
  // One register access and the longest FIFO read, with a few cycles of step overhead
  localparam int REG_SPI   = 16 * CLK_DIV * 2 + 4;
  localparam int FIFO_SPI  = 16 * CLK_DIV * MAX_BYTES + 4;
  localparam int XFER_TIME = POLL + XFER_WAIT + 4 * REG_SPI + FIFO_SPI;
  localparam int WATCHDOG  = 2 * (20 + SETTLE + 16 * REG_SPI + (NUM_XFERS + 2) * XFER_TIME);

  // Transfer 2 is a NAK, counts below 4 carry no packet
  localparam byte_t HRSL_TBL [NUM_XFERS]  = '{0, 0, 4, 0, 0, 0, 0, 0, 0, 0};
  localparam byte_t COUNT_TBL [NUM_XFERS] = '{4, 8, 5, 6, 0, 2, 3, 7, 1, 5};
  localparam logic [4:0] BRINGUP_REG [9] = '{PINCTL, USBCTL, USBCTL, IOPINS1, MODE, HIEN,
                                            HCTL, HCTL, MODE};
  localparam byte_t BRINGUP_VAL [9] = '{FULLDUPLEX_VAL, CHIPRES_VAL, 8'h00, POWER_VAL,
                                       HOSTMODE_VAL, HIEN_VAL, SAMPLEBUS_VAL, BUSRST_VAL,
                                       HOSTMODE_VAL};

  logic        clk_in;
  logic        rst_in;
  logic        miso_in;
  logic        n_rst_out;
  logic        n_ss_out;
  logic        mosi_out;
  logic        sclk_out;
  logic        ready;
  logic [31:0] midi_word;
  logic        midi_valid;
  logic [31:0] expected_words [$];
  logic        ready_seen = 1'b0;
  int          seed = 51612;
  int          errors = 0;
  int          checks = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          test_start = 0;
  int          delivered = 0;

  usb_midi_host #(
    .MAX_BYTES        (MAX_BYTES),
    .CLK_DIV          (CLK_DIV),
    .SETTLE_CYCLES    (SETTLE),
    .POLL_CYCLES      (POLL),
    .XFER_WAIT_CYCLES (XFER_WAIT)
  ) usb_midi_host_inst (
    .clk_in     (clk_in),
    .rst_in     (rst_in),
    .miso_in    (miso_in),
    .n_rst_out  (n_rst_out),
    .n_ss_out   (n_ss_out),
    .mosi_out   (mosi_out),
    .sclk_out   (sclk_out),
    .ready      (ready),
    .midi_word  (midi_word),
    .midi_valid (midi_valid)
  );

  max3421_model model_inst (
    .sclk (sclk_out),
    .mosi (mosi_out),
    .n_ss (n_ss_out),
    .miso (miso_in)
  );

  bind max3421_spi usb_midi_host_chk usb_midi_host_chk_inst (
    .clk_in   (clk_in),
    .rst_in   (rst_in),
    .start    (start),
    .busy     (busy),
    .done     (done),
    .n_ss_out (n_ss_out),
    .sclk_out (sclk_out)
  );

  // Packet in bits 31..0, bit 32 set when the transfer yields one
  function automatic logic [32:0] expected_packet(input byte_t hrsl, input byte_t count,
                                                  input byte_t data [8]);
    logic [32:0] pkt;
    pkt = '0;
    if (hrsl[HRSLT_WIDTH-1:0] == '0 && count >= 8'd4) begin
      pkt = {1'b1, data[0], data[1], data[2], data[3]};
    end
    return pkt;
  endfunction

  task automatic check_true(input logic cond, input string msg);
    checks++;
    assert (cond) else begin
      $display("CHECK FAILED at %0t ns: %s", $time, msg);
      errors++;
    end
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors == test_start) begin
      $display("test %s: passed", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, errors - test_start);
    end
    test_start = errors;
  endtask

  task automatic load_transfers();
    byte_t       row [8];
    logic [32:0] pkt;
    for (int i = 0; i < NUM_XFERS; i++) begin
      for (int j = 0; j < 8; j++) begin
        row[j] = byte_t'($random(seed));
        model_inst.xfer_data[i][j] = row[j];
      end
      model_inst.xfer_hrsl[i]  = HRSL_TBL[i];
      model_inst.xfer_count[i] = COUNT_TBL[i];
      pkt = expected_packet(HRSL_TBL[i], COUNT_TBL[i], row);
      if (pkt[32]) begin
        expected_words.push_back(pkt[31:0]);
      end
    end
    model_inst.num_xfers = NUM_XFERS;
  endtask

  initial begin
    clk_in = 1'b0;
    forever #5 clk_in = ~clk_in;
  end

  initial begin : watchdog
    repeat (WATCHDOG) @(posedge clk_in);
    $display("Timeout: the run did not finish within %0d clock cycles", WATCHDOG);
    $display("Simulation failed");
    $finish;
  end

  always @(posedge clk_in) begin : compare_packets
    logic [31:0] want;
    if (!rst_in && midi_valid) begin
      delivered++;
      if (expected_words.size() == 0) begin
        check_true(1'b0, $sformatf("unexpected packet %h", midi_word));
      end else begin
        want = expected_words.pop_front();
        check_true(midi_word == want,
                   $sformatf("packet %0d expected %h got %h", delivered, want, midi_word));
      end
    end
    if (ready_seen && !ready) begin
      check_true(1'b0, "ready fell after it had risen");
    end
    ready_seen <= ready_seen || ready;
  end

  initial begin : main_flow
    int want_len;
    int total;
    rst_in = 1'b1;
    load_transfers();
    for (int i = 0; i < 10; i++) begin
      @(posedge clk_in);
      if (i > 0) begin
        check_true(!ready && !midi_valid && !n_rst_out, "ready, midi_valid or n_rst_out high");
        check_true(n_ss_out && !sclk_out, "SPI pins not idle in reset");
      end
    end
    rst_in <= 1'b0;
    @(posedge clk_in);
    check_true(!n_rst_out, "n_rst_out released in the reset release cycle");
    @(posedge clk_in);
    check_true(n_rst_out, "n_rst_out not high one cycle after reset release");
    end_test("reset");

    while (!ready) @(posedge clk_in);
    check_true(model_inst.frame_reported, "ready rose before the frame bit was read");
    check_true(model_inst.wr_count == 9,
               $sformatf("expected 9 writes before ready, saw %0d", model_inst.wr_count));
    for (int i = 0; i < 9; i++) begin
      check_true(model_inst.wr_reg[i] == BRINGUP_REG[i] && model_inst.wr_val[i] == BRINGUP_VAL[i],
                 $sformatf("write %0d expected reg %0d = %h, got reg %0d = %h", i,
                           BRINGUP_REG[i], BRINGUP_VAL[i], model_inst.wr_reg[i],
                           model_inst.wr_val[i]));
    end
    end_test("bring-up");

    // The launch after the table ends sees a NAK, so every packet is out by then
    while (model_inst.xfer_idx <= NUM_XFERS) @(posedge clk_in);
    @(posedge clk_in);
    check_true(expected_words.size() == 0,
               $sformatf("%0d packets never delivered", expected_words.size()));
    check_true(model_inst.early_bulk == 0, "bulk-IN launched before the frame bit");
    end_test("packets");

    check_true(!model_inst.rcvbc_read[2], "RCVBC read after a NAK");
    check_true(model_inst.fifo_len[2] == 0, "FIFO read after a NAK");
    check_true(model_inst.rcvbc_read[3], "transfer after the NAK not read");
    end_test("nak");

    for (int i = 0; i < NUM_XFERS; i++) begin
      if (HRSL_TBL[i] == 8'd0) begin
        want_len = (COUNT_TBL[i] == 8'd0) ? 0 : int'(COUNT_TBL[i]) + 1;
        check_true(model_inst.fifo_len[i] == want_len,
                   $sformatf("transfer %0d FIFO read length expected %0d got %0d", i,
                             want_len, model_inst.fifo_len[i]));
      end
    end
    end_test("fifo length");

    total = errors + usb_midi_host_inst.max3421_spi_inst.usb_midi_host_chk_inst.fail_count;
    $display("tests run %0d, failed %0d, checks %0d, errors %0d, packets %0d",
             tests_run, tests_failed, checks, total, delivered);
    if (total == 0 && tests_failed == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== usb_midi_host_chk.sv ====
module usb_midi_host_chk (
  input logic clk_in,
  input logic rst_in,
  input logic start,
  input logic busy,
  input logic done,
  input logic n_ss_out,
  input logic sclk_out
);
  timeunit 1ns;
  timeprecision 100ps;

  int fail_count = 0;

  // Mode 0 clock idles low while the chip is deselected
  sclk_idle: assert property (@(posedge clk_in) disable iff (rst_in) n_ss_out |-> !sclk_out)
    else begin
      $error("sclk_out high while n_ss_out is high");
      fail_count++;
    end

  done_pulse: assert property (@(posedge clk_in) disable iff (rst_in) done |=> !done)
    else begin
      $error("done longer than one cycle");
      fail_count++;
    end

  start_idle: assert property (@(posedge clk_in) disable iff (rst_in) start |-> !busy)
    else begin
      $error("start raised while the SPI engine is busy");
      fail_count++;
    end

endmodule

// ==== max3421_model.sv ====
module max3421_model import usb_host_pkg::*; #(
  parameter int MAX_XFERS = 16
) (
  input  logic sclk,
  input  logic mosi,
  input  logic n_ss,
  output logic miso
);
  timeunit 1ns;
  timeprecision 100ps;

  // Transfer table loaded by the testbench
  int         num_xfers = 0;
  byte_t      xfer_hrsl [MAX_XFERS];
  byte_t      xfer_count [MAX_XFERS];
  byte_t      xfer_data [MAX_XFERS][8];
  // What the host did, kept for the testbench to compare
  logic       rcvbc_read [MAX_XFERS];
  int         fifo_len [MAX_XFERS];
  logic [4:0] wr_reg [64];
  byte_t      wr_val [64];
  int         wr_count = 0;
  int         xfer_idx = 0;
  int         early_bulk = 0;
  logic       frame_reported = 1'b0;

  int         cur = -1;
  int         bit_cnt = 0;
  int         byte_num = 0;
  int         fifo_pos = 0;
  int         irq_reads = 0;
  int         hctl_reads = 0;
  int         hirq_reads = 0;
  logic [4:0] cur_reg = '0;
  logic       cur_write = 1'b1;
  byte_t      rx_sr = '0;
  byte_t      tx_sr = '0;
  byte_t      next_tx = '0;

  initial begin
    miso = 1'b0;
    for (int i = 0; i < MAX_XFERS; i++) begin
      rcvbc_read[i] = 1'b0;
      fifo_len[i]   = 0;
    end
  end

  function automatic logic live();
    return (cur >= 0) && (cur < num_xfers);
  endfunction

  function automatic byte_t read_reg(input logic [4:0] addr);
    byte_t val;
    val = 8'h00;
    case (addr)
      // Oscillator, bus reset and frame each settle on the second read
      USBIRQ: begin
        irq_reads++;
        val[OSCOK_BIT] = (irq_reads >= 2);
      end
      HCTL: begin
        hctl_reads++;
        val[BUSRST_BIT] = (hctl_reads < 2);
      end
      HIRQ: begin
        hirq_reads++;
        val[FRAME_BIT] = (hirq_reads >= 2);
        frame_reported = frame_reported || (hirq_reads >= 2);
      end
      // Launches past the end of the table get a NAK
      HRSL: val = live() ? xfer_hrsl[cur] : 8'h04;
      RCVBC: begin
        if (live()) begin
          rcvbc_read[cur] = 1'b1;
          val = xfer_count[cur];
        end
      end
      RCVFIFO: begin
        if (live() && fifo_pos < 8) begin
          val = xfer_data[cur][fifo_pos];
        end
        fifo_pos++;
      end
      default: val = 8'h00;
    endcase
    return val;
  endfunction

  task automatic take_byte(input byte_t b);
    if (byte_num == 0) begin
      cur_reg   = b[7:3];
      cur_write = b[CMD_WRITE_BIT];
      next_tx   = cur_write ? 8'h00 : read_reg(b[7:3]);
    end else if (cur_write) begin
      if (byte_num == 1 && wr_count < 64) begin
        wr_reg[wr_count] = cur_reg;
        wr_val[wr_count] = b;
        wr_count++;
      end
      // Each bulk-IN launch takes the next transfer from the table
      if (byte_num == 1 && cur_reg == HXFR && b == BULK_IN_VAL) begin
        if (!frame_reported) begin
          early_bulk++;
        end
        cur = xfer_idx;
        xfer_idx++;
      end
      next_tx = 8'h00;
    end else begin
      next_tx = (cur_reg == RCVFIFO) ? read_reg(RCVFIFO) : 8'h00;
    end
  endtask

  // Status byte goes out first
  always @(negedge n_ss) begin
    bit_cnt  = 0;
    byte_num = 0;
    fifo_pos = 0;
    tx_sr    = 8'h00;
    miso     = tx_sr[7];
  end

  always @(posedge sclk) begin
    if (!n_ss) begin
      rx_sr = {rx_sr[6:0], mosi};
      bit_cnt++;
      if (bit_cnt == 8) begin
        take_byte(rx_sr);
        bit_cnt = 0;
        byte_num++;
      end
    end
  end

  always @(negedge sclk) begin
    if (!n_ss) begin
      if (bit_cnt == 0) begin
        tx_sr = next_tx;
      end else begin
        tx_sr = tx_sr << 1;
      end
      miso = tx_sr[7];
    end
  end

  // FIFO read length counts the command byte too
  always @(posedge n_ss) begin
    if (!cur_write && cur_reg == RCVFIFO && live()) begin
      fifo_len[cur] = byte_num;
    end
  end

endmodule

// ==== usb_midi_host.sv ====
module usb_midi_host import usb_host_pkg::*; #(
  parameter int MAX_BYTES        = 9,
  parameter int CLK_DIV          = 4,
  parameter int SETTLE_CYCLES    = 1_250_000,
  parameter int POLL_CYCLES      = 100_000,
  parameter int XFER_WAIT_CYCLES = 20
) (
  input  logic        clk_in,
  input  logic        rst_in,
  input  logic        miso_in,
  output logic        n_rst_out,
  output logic        n_ss_out,
  output logic        mosi_out,
  output logic        sclk_out,
  output logic        ready,
  output logic [31:0] midi_word,
  output logic        midi_valid
);

  step_t                  step;
  byte_t                  rx_count;
  byte_t                  tx_count;
  logic [8*MAX_BYTES-1:0] tx_bytes;
  logic [8*MAX_BYTES-1:0] rx_bytes;
  logic                   start;
  logic                   done;

  usb_host_fsm #(
    .MAX_BYTES        (MAX_BYTES),
    .SETTLE_CYCLES    (SETTLE_CYCLES),
    .POLL_CYCLES      (POLL_CYCLES),
    .XFER_WAIT_CYCLES (XFER_WAIT_CYCLES)
  ) usb_host_fsm_inst (
    .clk_in     (clk_in),
    .rst_in     (rst_in),
    .done       (done),
    .rx_bytes   (rx_bytes),
    .step       (step),
    .rx_count   (rx_count),
    .start      (start),
    .n_rst_out  (n_rst_out),
    .ready      (ready),
    .midi_word  (midi_word),
    .midi_valid (midi_valid)
  );

  max3421_cmd_rom #(
    .MAX_BYTES (MAX_BYTES)
  ) max3421_cmd_rom_inst (
    .step     (step),
    .rx_count (rx_count),
    .tx_bytes (tx_bytes),
    .tx_count (tx_count)
  );

  // Sequencer starts only in the cycle after done, when the engine is idle again
  max3421_spi #(
    .MAX_BYTES (MAX_BYTES),
    .CLK_DIV   (CLK_DIV)
  ) max3421_spi_inst (
    .clk_in   (clk_in),
    .rst_in   (rst_in),
    .start    (start),
    .tx_bytes (tx_bytes),
    .tx_count (tx_count),
    .miso_in  (miso_in),
    .busy     (),
    .done     (done),
    .rx_bytes (rx_bytes),
    .n_ss_out (n_ss_out),
    .mosi_out (mosi_out),
    .sclk_out (sclk_out)
  );

endmodule

// ==== usb_host_fsm.sv ====
module usb_host_fsm import usb_host_pkg::*; #(
  parameter int MAX_BYTES        = 9,
  parameter int SETTLE_CYCLES    = 1_250_000,
  parameter int POLL_CYCLES      = 100_000,
  parameter int XFER_WAIT_CYCLES = 20
) (
  input  logic                   clk_in,
  input  logic                   rst_in,
  input  logic                   done,
  input  logic [8*MAX_BYTES-1:0] rx_bytes,
  output step_t                  step,
  output byte_t                  rx_count,
  output logic                   start,
  output logic                   n_rst_out,
  output logic                   ready,
  output logic [31:0]            midi_word,
  output logic                   midi_valid
);

  localparam int LONGEST  = (SETTLE_CYCLES > POLL_CYCLES) ? SETTLE_CYCLES : POLL_CYCLES;
  localparam int WAIT_MAX = (LONGEST > XFER_WAIT_CYCLES) ? LONGEST : XFER_WAIT_CYCLES;
  localparam int WAIT_W   = $clog2(WAIT_MAX + 1);

  step_t             next_step;
  byte_t             reg_data;
  logic [WAIT_W-1:0] wait_cnt;
  logic [WAIT_W-1:0] wait_len;
  logic              waiting;
  logic              advance;

  function automatic logic is_wait(input step_t s);
    return s inside {IDLE, SETTLE, XFER_WAIT, POLL_WAIT};
  endfunction

  // Byte 0 is the chip status, byte 1 the register value
  assign reg_data = rx_bytes[15:8];
  assign waiting  = is_wait(step);
  assign advance  = waiting ? (wait_cnt == wait_len) : done;

  always_comb begin
    case (step)
      SETTLE:    wait_len = WAIT_W'(SETTLE_CYCLES - 1);
      XFER_WAIT: wait_len = WAIT_W'(XFER_WAIT_CYCLES - 1);
      POLL_WAIT: wait_len = WAIT_W'(POLL_CYCLES - 1);
      default:   wait_len = '0;
    endcase
  end

  always_comb begin
    next_step = step;
    case (step)
      IDLE:         next_step = SET_DUPLEX;
      SET_DUPLEX:   next_step = CHIP_RESET;
      CHIP_RESET:   next_step = CHIP_RELEASE;
      CHIP_RELEASE: next_step = READ_OSC;
      // Poll until the oscillator is stable
      READ_OSC:     next_step = reg_data[OSCOK_BIT] ? SET_POWER : READ_OSC;
      SET_POWER:    next_step = SET_HOST;
      SET_HOST:     next_step = SET_IRQ_EN;
      SET_IRQ_EN:   next_step = SAMPLE_BUS;
      SAMPLE_BUS:   next_step = SETTLE;
      SETTLE:       next_step = BUS_RESET;
      BUS_RESET:    next_step = READ_BUSRST;
      // BUSRST self-clears when the bus reset is over
      READ_BUSRST:  next_step = reg_data[BUSRST_BIT] ? READ_BUSRST : START_SOF;
      START_SOF:    next_step = READ_FRAME;
      READ_FRAME:   next_step = reg_data[FRAME_BIT] ? BULK_IN_XFR : READ_FRAME;
      BULK_IN_XFR:  next_step = XFER_WAIT;
      XFER_WAIT:    next_step = READ_RESULT;
      // Any nonzero HRSLT (NAK included) retries after the poll wait
      READ_RESULT: begin
        if (reg_data[HRSLT_WIDTH-1:0] == '0) begin
          next_step = CLEAR_IRQ;
        end else begin
          next_step = POLL_WAIT;
        end
      end
      CLEAR_IRQ:    next_step = READ_COUNT;
      READ_COUNT:   next_step = (reg_data != 8'd0) ? READ_FIFO : POLL_WAIT;
      READ_FIFO:    next_step = POLL_WAIT;
      POLL_WAIT:    next_step = BULK_IN_XFR;
      default:      next_step = IDLE;
    endcase
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      step       <= IDLE;
      start      <= 1'b0;
      n_rst_out  <= 1'b0;
      ready      <= 1'b0;
      midi_valid <= 1'b0;
      wait_cnt   <= '0;
    end else begin
      n_rst_out  <= 1'b1;
      start      <= 1'b0;
      midi_valid <= 1'b0;
      if (advance) begin
        step     <= next_step;
        // Launch every register step, repeated polls included
        start    <= !is_wait(next_step);
        wait_cnt <= '0;
        if (step == READ_FRAME && reg_data[FRAME_BIT]) begin
          ready <= 1'b1;
        end
        if (step == READ_FIFO) begin
          midi_valid <= (rx_count >= 8'd4);
        end
      end else if (waiting) begin
        wait_cnt <= wait_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (step == READ_COUNT && done) begin
      rx_count <= reg_data;
    end
    // First FIFO byte lands in the top byte
    if (step == READ_FIFO && done) begin
      midi_word <= {rx_bytes[8 +: 8], rx_bytes[16 +: 8], rx_bytes[24 +: 8], rx_bytes[32 +: 8]};
    end
  end

endmodule

// ==== max3421_cmd_rom.sv ====
module max3421_cmd_rom import usb_host_pkg::*; #(
  parameter int MAX_BYTES = 9
) (
  input  step_t                  step,
  input  byte_t                  rx_count,
  output logic [8*MAX_BYTES-1:0] tx_bytes,
  output byte_t                  tx_count
);

  byte_t fifo_len;

  function automatic byte_t cmd_byte(input logic [4:0] addr, input logic write);
    byte_t cmd;
    cmd = {addr, 3'b000};
    cmd[CMD_WRITE_BIT] = write;
    return cmd;
  endfunction

  // Command byte plus the FIFO bytes, limited to what the engine can hold
  always_comb begin
    if (rx_count >= byte_t'(MAX_BYTES - 1)) begin
      fifo_len = byte_t'(MAX_BYTES);
    end else begin
      fifo_len = rx_count + 8'd1;
    end
  end

  always_comb begin
    tx_bytes = '0;
    tx_count = 8'd2;
    case (step)
      SET_DUPLEX:   tx_bytes[15:0] = {FULLDUPLEX_VAL, cmd_byte(PINCTL, 1'b1)};
      CHIP_RESET:   tx_bytes[15:0] = {CHIPRES_VAL, cmd_byte(USBCTL, 1'b1)};
      CHIP_RELEASE: tx_bytes[15:0] = {8'h00, cmd_byte(USBCTL, 1'b1)};
      READ_OSC:     tx_bytes[7:0] = cmd_byte(USBIRQ, 1'b0);
      SET_POWER:    tx_bytes[15:0] = {POWER_VAL, cmd_byte(IOPINS1, 1'b1)};
      SET_HOST:     tx_bytes[15:0] = {HOSTMODE_VAL, cmd_byte(MODE, 1'b1)};
      SET_IRQ_EN:   tx_bytes[15:0] = {HIEN_VAL, cmd_byte(HIEN, 1'b1)};
      SAMPLE_BUS:   tx_bytes[15:0] = {SAMPLEBUS_VAL, cmd_byte(HCTL, 1'b1)};
      BUS_RESET:    tx_bytes[15:0] = {BUSRST_VAL, cmd_byte(HCTL, 1'b1)};
      READ_BUSRST:  tx_bytes[7:0] = cmd_byte(HCTL, 1'b0);
      // Host mode value already has SOFKAENAB set
      START_SOF:    tx_bytes[15:0] = {HOSTMODE_VAL, cmd_byte(MODE, 1'b1)};
      READ_FRAME:   tx_bytes[7:0] = cmd_byte(HIRQ, 1'b0);
      BULK_IN_XFR:  tx_bytes[15:0] = {BULK_IN_VAL, cmd_byte(HXFR, 1'b1)};
      READ_RESULT:  tx_bytes[7:0] = cmd_byte(HRSL, 1'b0);
      CLEAR_IRQ:    tx_bytes[15:0] = {HIRQ_CLEAR_VAL, cmd_byte(HIRQ, 1'b1)};
      READ_COUNT:   tx_bytes[7:0] = cmd_byte(RCVBC, 1'b0);
      READ_FIFO: begin
        tx_bytes[7:0] = cmd_byte(RCVFIFO, 1'b0);
        tx_count      = fifo_len;
      end
      // IDLE and the wait steps send nothing
      default:      tx_count = 8'd0;
    endcase
  end

endmodule

// ==== max3421_spi.sv ====
module max3421_spi import usb_host_pkg::*; #(
  parameter int MAX_BYTES = 9,
  parameter int CLK_DIV   = 4
) (
  input  logic                   clk_in,
  input  logic                   rst_in,
  input  logic                   start,
  input  logic [8*MAX_BYTES-1:0] tx_bytes,
  input  byte_t                  tx_count,
  input  logic                   miso_in,
  output logic                   busy,
  output logic                   done,
  output logic [8*MAX_BYTES-1:0] rx_bytes,
  output logic                   n_ss_out,
  output logic                   mosi_out,
  output logic                   sclk_out
);

  localparam int DIV_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;
  localparam int IDX_W = (MAX_BYTES > 1) ? $clog2(MAX_BYTES) : 1;

  logic [8*MAX_BYTES-1:0] tx_reg;
  logic [IDX_W-1:0]       byte_idx;
  logic [IDX_W-1:0]       last_idx;
  logic [IDX_W-1:0]       next_byte;
  logic [2:0]             bit_idx;
  logic [2:0]             next_bit;
  logic [DIV_W-1:0]       div_cnt;
  logic [6:0]             rx_shift;
  logic                   finish;
  logic                   launch;
  logic                   tick;
  logic                   rise;
  logic                   fall;
  logic                   last_bit;

  assign launch   = start && !busy;
  assign tick     = busy && !finish && (div_cnt == DIV_W'(CLK_DIV - 1));
  assign rise     = tick && !sclk_out;
  assign fall     = tick && sclk_out;
  assign last_bit = (byte_idx == last_idx) && (bit_idx == 3'd0);

  // Position of the bit shifted out after the next falling edge
  always_comb begin
    if (bit_idx == 3'd0) begin
      next_byte = byte_idx + 1'b1;
      next_bit  = 3'd7;
    end else begin
      next_byte = byte_idx;
      next_bit  = bit_idx - 1'b1;
    end
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      busy     <= 1'b0;
      done     <= 1'b0;
      finish   <= 1'b0;
      n_ss_out <= 1'b1;
      sclk_out <= 1'b0;
      mosi_out <= 1'b0;
      div_cnt  <= '0;
      byte_idx <= '0;
      bit_idx  <= '0;
    end else begin
      done <= 1'b0;
      if (launch) begin
        busy     <= 1'b1;
        n_ss_out <= 1'b0;
        div_cnt  <= '0;
        byte_idx <= '0;
        bit_idx  <= 3'd7;
        // MSB of byte 0 is on the line before the first rising edge
        mosi_out <= tx_bytes[7];
      end else if (finish) begin
        // One idle cycle with sclk low before the chip is deselected
        finish   <= 1'b0;
        busy     <= 1'b0;
        done     <= 1'b1;
        n_ss_out <= 1'b1;
        mosi_out <= 1'b0;
      end else if (busy) begin
        if (tick) begin
          div_cnt  <= '0;
          sclk_out <= !sclk_out;
        end else begin
          div_cnt <= div_cnt + 1'b1;
        end
        if (fall) begin
          if (last_bit) begin
            finish <= 1'b1;
          end else begin
            byte_idx <= next_byte;
            bit_idx  <= next_bit;
            mosi_out <= tx_reg[{next_byte, next_bit}];
          end
        end
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (launch) begin
      tx_reg   <= tx_bytes;
      last_idx <= IDX_W'(tx_count - 8'd1);
    end
    // Sample on the rising edge, data has been stable since the last fall
    if (rise) begin
      rx_shift <= {rx_shift[5:0], miso_in};
      if (bit_idx == 3'd0) begin
        rx_bytes[8*byte_idx +: 8] <= {rx_shift, miso_in};
      end
    end
  end

endmodule

// ==== usb_host_pkg.sv ====
package usb_host_pkg;

  typedef logic [7:0] byte_t;

  // MAX3421E register numbers
  localparam logic [4:0] RCVFIFO = 5'd1;
  localparam logic [4:0] RCVBC   = 5'd6;
  localparam logic [4:0] USBIRQ  = 5'd13;
  localparam logic [4:0] USBCTL  = 5'd15;
  localparam logic [4:0] PINCTL  = 5'd17;
  localparam logic [4:0] IOPINS1 = 5'd20;
  localparam logic [4:0] HIRQ    = 5'd25;
  localparam logic [4:0] HIEN    = 5'd26;
  localparam logic [4:0] MODE    = 5'd27;
  localparam logic [4:0] HCTL    = 5'd29;
  localparam logic [4:0] HXFR    = 5'd30;
  localparam logic [4:0] HRSL    = 5'd31;

  // Command byte is {reg, 0, dir, ackstat}
  localparam int CMD_WRITE_BIT = 1;

  // FDUPSPI and POSINT
  localparam byte_t FULLDUPLEX_VAL = 8'b0001_0100;
  localparam byte_t CHIPRES_VAL    = 8'b0010_0000;
  // GPOUT0 drives the VBUS switch
  localparam byte_t POWER_VAL      = 8'b0000_0001;
  // DPPULLDN, DMPULLDN, SEPIRQ, SOFKAENAB, HOST
  localparam byte_t HOSTMODE_VAL   = 8'b1101_1001;
  localparam byte_t HIEN_VAL       = 8'b0110_0000;
  localparam byte_t SAMPLEBUS_VAL  = 8'b0000_0100;
  localparam byte_t BUSRST_VAL     = 8'b0000_0001;
  localparam byte_t HIRQ_CLEAR_VAL = 8'b1111_1111;
  // Bulk IN on endpoint 3
  localparam byte_t BULK_IN_VAL    = 8'b0000_0011;

  localparam int OSCOK_BIT   = 0;
  localparam int BUSRST_BIT  = 0;
  localparam int FRAME_BIT   = 6;
  localparam int HRSLT_WIDTH = 4;

  typedef enum {
    IDLE, SET_DUPLEX, CHIP_RESET, CHIP_RELEASE, READ_OSC, SET_POWER, SET_HOST, SET_IRQ_EN,
    SAMPLE_BUS, SETTLE, BUS_RESET, READ_BUSRST, START_SOF, READ_FRAME,
    BULK_IN_XFR, XFER_WAIT, READ_RESULT, CLEAR_IRQ, READ_COUNT, READ_FIFO, POLL_WAIT
  } step_t;

endpackage
